/* Makefile */
# Verilator build and run of the microcode unit testbench.

VERILATOR ?= verilator
TOP       ?= microcode_unit_tb
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary -j 0
PASS_MSG  ?= === PASS ===

SOURCES := $(wildcard source/*.sv include/*.svh tb/*.sv)
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The run fails unless the pass line shows up in the simulator output.
run: compile
	@out="$$(./$(SIM_BIN))"; echo "$$out"; \
	if echo "$$out" | grep -qxF '$(PASS_MSG)'; then \
	  echo "Simulation passed"; \
	else \
	  echo "Simulation failed"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR)

/* include/microcode_config.svh */
`ifndef MICROCODE_CONFIG_SVH
`define MICROCODE_CONFIG_SVH

// Address fields presented to the microcode ROM.
`define MC_OPCODE_W 6     // Opcode register width.
`define MC_STEP_W 5       // Micro-op counter width, up to 32 steps per program.

// Control word geometry.
`define MC_WORD_W 32      // Full control word.
`define MC_CTRL_DATA_W 8  // Constant data field in bits 7:0.

// Fixed register numbers used by the micro-programs.
`define MC_REG_PC 31      // r31 is the program counter.

`endif

/* sim.f */
+incdir+include
source/microcode_pkg.sv
source/microcode_bus_if.sv
source/uop_sequencer.sv
source/alu_sequence.sv
source/branch_sequence.sv
source/microcode_rom.sv
source/microcode_unit.sv
tb/microcode_unit_tb.sv

/* source/alu_sequence.sv */
`timescale 1ns/1ps
`include "microcode_config.svh"

module alu_sequence (
  input  microcode_pkg::opcode_e         opcode,
  input  logic [`MC_STEP_W-1:0]          step,
  output microcode_pkg::control_word_t   word,
  output logic                           hit
);

  logic                           imm_src;      // Second operand is the immediate.
  logic                           use_shifter;  // Result from the shifter, not the MLU.
  microcode_pkg::mlu_op_e         mlu_op;
  microcode_pkg::shifter_plane_e  shift_dir;

  // Per-opcode operation select.
  always_comb begin
    hit         = 1'b1;
    imm_src     = 1'b0;
    use_shifter = 1'b0;
    mlu_op      = microcode_pkg::MLU_ADD;
    shift_dir   = microcode_pkg::SHIFTER_LEFT;
    case (opcode)
      microcode_pkg::OP_ADDU: imm_src = 1'b1;
      microcode_pkg::OP_AND: begin
        imm_src = 1'b1;
        mlu_op  = microcode_pkg::MLU_AND;
      end
      microcode_pkg::OP_SLL: begin
        imm_src     = 1'b1;
        use_shifter = 1'b1;
      end
      microcode_pkg::OP_SRL: begin
        imm_src     = 1'b1;
        use_shifter = 1'b1;
        shift_dir   = microcode_pkg::SHIFTER_RIGHT;
      end
      microcode_pkg::OP_ADD3: mlu_op = microcode_pkg::MLU_ADD;
      microcode_pkg::OP_OR3:  mlu_op = microcode_pkg::MLU_OR;
      microcode_pkg::OP_XOR3: mlu_op = microcode_pkg::MLU_XOR;
      microcode_pkg::OP_SLL3: use_shifter = 1'b1;  // Shift amount from rB.
      default: hit = 1'b0;
    endcase
  end

  always_comb begin
    word = '0;
    if (hit) begin
      case (step)
        0: begin  // Source register into TMP0.
          word.reg_sel   = microcode_pkg::REG_SEL_OPWORD1;
          word.out_plane = microcode_pkg::OUT_REG;
          word.in_plane  = microcode_pkg::IN_TMP0;
        end
        1: begin  // Second operand into TMP1.
          if (imm_src) begin
            word.out_plane = microcode_pkg::OUT_OPWORD_IMMEDIATE;
          end else begin
            word.reg_sel   = microcode_pkg::REG_SEL_OPWORD2;
            word.out_plane = microcode_pkg::OUT_REG;
          end
          word.in_plane = microcode_pkg::IN_TMP1;
        end
        2: begin  // Result into rD.
          word.reg_sel  = microcode_pkg::REG_SEL_OPWORD0;
          word.in_plane = microcode_pkg::IN_REG;
          if (use_shifter) begin
            word.out_plane     = microcode_pkg::OUT_SHIFTER;
            word.shifter_plane = shift_dir;
          end else begin
            word.out_plane = microcode_pkg::OUT_MLU;
            word.mlu_op    = mlu_op;
          end
        end
        3: word = microcode_pkg::go_fetch_word();
        default: word = '0;
      endcase
    end
  end

endmodule

/* source/branch_sequence.sv */
`timescale 1ns/1ps
`include "microcode_config.svh"

module branch_sequence (
  input  microcode_pkg::opcode_e         opcode,
  input  logic [`MC_STEP_W-1:0]          step,
  input  logic                           cond_var,  // Zero flag of the compare.
  output microcode_pkg::control_word_t   word,
  output logic                           hit
);

  logic taken;

  assign hit   = (opcode == microcode_pkg::OP_BEQ) || (opcode == microcode_pkg::OP_BNE);
  assign taken = (opcode == microcode_pkg::OP_BEQ) ? cond_var : !cond_var;  // BNE inverts.

  always_comb begin
    word = '0;
    if (hit) begin
      case (step)
        0: begin  // rA into TMP0.
          word.reg_sel   = microcode_pkg::REG_SEL_OPWORD0;
          word.out_plane = microcode_pkg::OUT_REG;
          word.in_plane  = microcode_pkg::IN_TMP0;
        end
        1: begin  // rB into TMP1.
          word.reg_sel   = microcode_pkg::REG_SEL_OPWORD1;
          word.out_plane = microcode_pkg::OUT_REG;
          word.in_plane  = microcode_pkg::IN_TMP1;
        end
        2: begin  // Compare, zero flag latched at the edge.
          word.mlu_op       = microcode_pkg::MLU_SUB;
          word.mlu_carry    = 1'b1;
          word.cond_var_sel = microcode_pkg::COND_SEL_MLU_ZERO;
        end
        3: begin
          if (taken) begin  // Offset into TMP0 ahead of the sign extend.
            word.out_plane = microcode_pkg::OUT_OPWORD_IMMEDIATE;
            word.in_plane  = microcode_pkg::IN_TMP0;
          end else begin
            word = microcode_pkg::go_fetch_word();
          end
        end
        4: begin  // Zero shift amount.
          word.out_plane = microcode_pkg::OUT_NONE;
          word.in_plane  = microcode_pkg::IN_TMP1;
        end
        5: begin  // Sign-extended offset into TMP1.
          word.shifter_plane = microcode_pkg::SHIFTER_SIGNEXT16;
          word.out_plane     = microcode_pkg::OUT_SHIFTER;
          word.in_plane      = microcode_pkg::IN_TMP1;
        end
        6: begin  // PC into TMP0.
          word.ctrl_data = `MC_CTRL_DATA_W'(`MC_REG_PC);
          word.reg_sel   = microcode_pkg::REG_SEL_CONTROL;
          word.out_plane = microcode_pkg::OUT_REG;
          word.in_plane  = microcode_pkg::IN_TMP0;
        end
        7: begin  // PC += offset.
          word.ctrl_data = `MC_CTRL_DATA_W'(`MC_REG_PC);
          word.reg_sel   = microcode_pkg::REG_SEL_CONTROL;
          word.out_plane = microcode_pkg::OUT_MLU;
          word.in_plane  = microcode_pkg::IN_REG;
          word.mlu_op    = microcode_pkg::MLU_ADD;
        end
        8: word = microcode_pkg::go_fetch_word();
        default: word = '0;
      endcase
    end
  end

endmodule

/* source/microcode_bus_if.sv */
`timescale 1ns/1ps
`include "microcode_config.svh"

// Address fields and control word between sequencer and ROM.
interface microcode_bus_if;
  microcode_pkg::opcode_e        opcode;    // Current opcode register.
  logic [`MC_STEP_W-1:0]         step;      // Micro-op counter.
  logic                          cond_var;  // Latched condition bit.
  microcode_pkg::control_word_t  word;      // Decoded control word.

  modport seq (
    output opcode, step, cond_var,
    input  word
  );

  modport rom (
    input  opcode, step, cond_var,
    output word
  );
endinterface

/* source/microcode_pkg.sv */
`include "microcode_config.svh"

package microcode_pkg;

  // Opcodes of the kept instructions, plus the two internal programs.
  typedef enum logic [`MC_OPCODE_W-1:0] {
    OP_RESET = 6'd0,  // Power-up program.
    OP_FETCH = 6'd1,  // Instruction fetch.
    OP_ADDU  = 6'd3,  // rD = rS + zeroext(I).
    OP_ADD3  = 6'd4,  // rD = rA + rB.
    OP_OR3   = 6'd6,  // rD = rA | rB.
    OP_BEQ   = 6'd8,  // Branch if rA == rB.
    OP_SLL   = 6'd10, // rD = rS << I.
    OP_BNE   = 6'd11, // Branch if rA != rB.
    OP_AND   = 6'd12, // rD = rS & zeroext(I).
    OP_XOR3  = 6'd13, // rD = rA ^ rB.
    OP_SRL   = 6'd14, // rD = rS >> I.
    OP_SLL3  = 6'd15  // rD = rA << rB.
  } opcode_e;

  typedef enum logic [1:0] {
    REG_SEL_OPWORD0,  // First register field of the opword.
    REG_SEL_OPWORD1,
    REG_SEL_OPWORD2,
    REG_SEL_CONTROL   // Register number comes from ctrl_data.
  } reg_sel_e;

  // Bus drivers.
  typedef enum logic [3:0] {
    OUT_NONE, OUT_REG, OUT_TMP0, OUT_TMP1, OUT_MMU, OUT_MLU, OUT_SHIFTER,
    OUT_TIMER, OUT_CTRL_DATA, OUT_OPWORD_IMMEDIATE
  } out_plane_e;

  // Bus loads; code 4 is unused.
  typedef enum logic [2:0] {
    IN_NONE   = 3'd0,
    IN_REG    = 3'd1,
    IN_TMP0   = 3'd2,
    IN_TMP1   = 3'd3,
    IN_OPWORD = 3'd5,
    IN_OPCODE = 3'd6  // Loads the sequencer opcode register.
  } in_plane_e;

  typedef enum logic [2:0] {
    MLU_ADD, MLU_SUB, MLU_AND, MLU_OR, MLU_XOR
  } mlu_op_e;

  typedef enum logic [1:0] {
    SHIFTER_LEFT, SHIFTER_RIGHT, SHIFTER_SIGNEXT16
  } shifter_plane_e;

  // Condition latched by the sequencer on the next edge.
  typedef enum logic [1:0] {
    COND_SEL_MLU_ZERO, COND_SEL_MLU_CARRY, COND_SEL_MLU_NEGATIVE, COND_SEL_INTERRUPT
  } cond_sel_e;

  typedef struct packed {
    logic [3:0]                  zero;          // Bits 31:28, always 0.
    cond_sel_e                   cond_var_sel;  // Bits 27:26.
    logic                        opcode_sel;    // 0 opword, 1 ctrl_data.
    logic                        shifter_arith;
    shifter_plane_e              shifter_plane;
    logic                        mlu_carry;
    mlu_op_e                     mlu_op;
    logic                        misc_plane;    // Resets the micro-op counter.
    in_plane_e                   in_plane;
    out_plane_e                  out_plane;
    reg_sel_e                    reg_sel;
    logic [`MC_CTRL_DATA_W-1:0]  ctrl_data;     // Bits 7:0.
  } control_word_t;

  // Last step of every program: load FETCH as the opcode and restart the counter.
  function automatic control_word_t go_fetch_word();
    control_word_t w;
    w            = '0;
    w.ctrl_data  = `MC_CTRL_DATA_W'(OP_FETCH);
    w.out_plane  = OUT_CTRL_DATA;
    w.in_plane   = IN_OPCODE;
    w.misc_plane = 1'b1;
    w.opcode_sel = 1'b1;  // Opcode taken from ctrl_data.
    return w;
  endfunction

endpackage

/* source/microcode_rom.sv */
`timescale 1ns/1ps
`include "microcode_config.svh"

module microcode_rom (
  microcode_bus_if.rom bus
);

  microcode_pkg::control_word_t  alu_word;
  microcode_pkg::control_word_t  br_word;
  logic                          alu_hit;
  logic                          br_hit;

  alu_sequence u_alu (
    .opcode (bus.opcode),
    .step   (bus.step),
    .word   (alu_word),
    .hit    (alu_hit)
  );

  branch_sequence u_branch (
    .opcode   (bus.opcode),
    .step     (bus.step),
    .cond_var (bus.cond_var),
    .word     (br_word),
    .hit      (br_hit)
  );

  always_comb begin
    bus.word = '0;
    case (bus.opcode)
      microcode_pkg::OP_RESET: begin
        case (bus.step)
          0: begin  // Clear the program counter.
            bus.word.ctrl_data = `MC_CTRL_DATA_W'(`MC_REG_PC);
            bus.word.reg_sel   = microcode_pkg::REG_SEL_CONTROL;
            bus.word.out_plane = microcode_pkg::OUT_NONE;  // Bus floats to zero.
            bus.word.in_plane  = microcode_pkg::IN_REG;
          end
          1: bus.word = microcode_pkg::go_fetch_word();
          default: bus.word = '0;
        endcase
      end
      microcode_pkg::OP_FETCH: begin
        case (bus.step)
          0: begin  // PC into TMP0 as the memory address.
            bus.word.ctrl_data = `MC_CTRL_DATA_W'(`MC_REG_PC);
            bus.word.reg_sel   = microcode_pkg::REG_SEL_CONTROL;
            bus.word.out_plane = microcode_pkg::OUT_REG;
            bus.word.in_plane  = microcode_pkg::IN_TMP0;
          end
          1: begin  // Memory data into the opword.
            bus.word.out_plane = microcode_pkg::OUT_MMU;
            bus.word.in_plane  = microcode_pkg::IN_OPWORD;
          end
          2: begin  // Increment of one into TMP1.
            bus.word.ctrl_data = `MC_CTRL_DATA_W'(1);
            bus.word.reg_sel   = microcode_pkg::REG_SEL_CONTROL;
            bus.word.out_plane = microcode_pkg::OUT_CTRL_DATA;
            bus.word.in_plane  = microcode_pkg::IN_TMP1;
          end
          3: begin  // PC = TMP0 + TMP1.
            bus.word.ctrl_data = `MC_CTRL_DATA_W'(`MC_REG_PC);
            bus.word.reg_sel   = microcode_pkg::REG_SEL_CONTROL;
            bus.word.out_plane = microcode_pkg::OUT_MLU;
            bus.word.in_plane  = microcode_pkg::IN_REG;
            bus.word.mlu_op    = microcode_pkg::MLU_ADD;
          end
          4: begin  // Hand over to the fetched opcode.
            bus.word.in_plane   = microcode_pkg::IN_OPCODE;
            bus.word.misc_plane = 1'b1;
            bus.word.opcode_sel = 1'b0;  // Opcode from the opword.
          end
          default: bus.word = '0;
        endcase
      end
      default: begin
        if (alu_hit) begin
          bus.word = alu_word;
        end else if (br_hit) begin
          bus.word = br_word;
        end  // Unknown opcodes keep the all-zero word.
      end
    endcase
  end

endmodule

/* source/microcode_unit.sv */
`timescale 1ns/1ps
`include "microcode_config.svh"

module microcode_unit (
  input  logic                     clk,
  input  logic                     arst_n,
  input  logic [`MC_OPCODE_W-1:0]  opword_opcode,  // Opcode field of the opword register.
  input  logic                     mlu_zero,
  input  logic                     mlu_carry_out,
  input  logic                     mlu_negative,
  input  logic                     interrupt,
  output logic [`MC_WORD_W-1:0]    control_word    // One word per micro-op step.
);

  microcode_bus_if bus ();

  // Opcode, step and condition registers.
  uop_sequencer u_seq (
    .clk           (clk),
    .arst_n        (arst_n),
    .opword_opcode (opword_opcode),
    .mlu_zero      (mlu_zero),
    .mlu_carry_out (mlu_carry_out),
    .mlu_negative  (mlu_negative),
    .interrupt     (interrupt),
    .bus           (bus.seq)
  );

  // Combinational decode of the current step.
  microcode_rom u_rom (
    .bus (bus.rom)
  );

  assign control_word = bus.word;

endmodule

/* source/uop_sequencer.sv */
`timescale 1ns/1ps
`include "microcode_config.svh"

module uop_sequencer (
  input  logic                     clk,
  input  logic                     arst_n,
  input  logic [`MC_OPCODE_W-1:0]  opword_opcode,  // From the opword register.
  input  logic                     mlu_zero,
  input  logic                     mlu_carry_out,
  input  logic                     mlu_negative,
  input  logic                     interrupt,
  microcode_bus_if.seq             bus
);

  microcode_pkg::opcode_e  opcode_q;
  logic [`MC_STEP_W-1:0]   step_q;
  logic                    cond_q;
  microcode_pkg::opcode_e  next_opcode;
  logic                    cond_next;

  // Opcode source for the counter reset.
  always_comb begin
    if (bus.word.opcode_sel) begin
      next_opcode = microcode_pkg::opcode_e'(bus.word.ctrl_data[`MC_OPCODE_W-1:0]);
    end else begin
      next_opcode = microcode_pkg::opcode_e'(opword_opcode);
    end
  end

  // Condition picked by the current word.
  always_comb begin
    case (bus.word.cond_var_sel)
      microcode_pkg::COND_SEL_MLU_ZERO:     cond_next = mlu_zero;
      microcode_pkg::COND_SEL_MLU_CARRY:    cond_next = mlu_carry_out;
      microcode_pkg::COND_SEL_MLU_NEGATIVE: cond_next = mlu_negative;
      default:                              cond_next = interrupt;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      opcode_q <= microcode_pkg::OP_RESET;  // First word is the clear-r31 step.
      step_q   <= '0;
      cond_q   <= 1'b0;
    end else begin
      cond_q <= cond_next;  // Latched every cycle.
      if (bus.word.misc_plane) begin
        step_q   <= '0;  // Program done.
        opcode_q <= next_opcode;
      end else begin
        step_q <= step_q + 1'b1;  // Wraps on unknown opcodes.
      end
    end
  end

  assign bus.opcode   = opcode_q;
  assign bus.step     = step_q;
  assign bus.cond_var = cond_q;

endmodule

/* tb/microcode_unit_tb.sv */
`timescale 1ns/1ps
`include "microcode_config.svh"

module microcode_unit_tb;

  localparam int CLK_HALF          = 4;   // 8 ns period.
  localparam int RESET_CYCLES      = 2;
  localparam int RESET_PROG_CYCLES = 2;   // Clear r31, then go-fetch.
  localparam int FETCH_CYCLES      = 5;
  localparam int ALU_CYCLES        = 4;
  localparam int BR_TAKEN_CYCLES   = 9;
  localparam int BR_SKIP_CYCLES    = 4;
  localparam int MARGIN            = 20;  // Slack on top of the tabled lengths.

  // One stimulus row.
  typedef struct packed {
    microcode_pkg::opcode_e     op;
    logic                       zero;     // mlu_zero during execution.
    logic [4:0]                 len;      // Execute cycles.
    logic [2:0]                 exp_sel;  // mlu_op or shifter_plane.
    microcode_pkg::out_plane_e  exp_out;
  } row_t;

  logic                           clk;
  logic                           arst_n;
  logic [`MC_OPCODE_W-1:0]        opword_opcode;
  logic                           mlu_zero;
  logic                           mlu_carry_out;
  logic                           mlu_negative;
  logic                           interrupt;
  logic [`MC_WORD_W-1:0]          control_word;

  microcode_pkg::control_word_t   w;            // Last sampled word.
  row_t                           rows[$];
  logic [31:0]                    rnd;
  int                             cycles = 0;
  int                             cycle_limit = 1000;

  microcode_unit dut (
    .clk           (clk),
    .arst_n        (arst_n),
    .opword_opcode (opword_opcode),
    .mlu_zero      (mlu_zero),
    .mlu_carry_out (mlu_carry_out),
    .mlu_negative  (mlu_negative),
    .interrupt     (interrupt),
    .control_word  (control_word)
  );

  initial begin
    clk = 1'b0;
    forever #CLK_HALF clk = ~clk;
  end

  // Run guard.
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles > cycle_limit) begin
      $display("=== FAIL ===");
      $fatal(1, "Timeout: the run did not finish within %0d clock cycles", cycle_limit);
    end
  end

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
    if (got !== expected) begin
      $display("** Error at %0t: %s = 0x%0h, expected 0x%0h", $time, name, got, expected);
      $display("=== FAIL ===");
      $fatal(1, "Check of %s failed", name);
    end
  endtask

  // Unselected condition sources toggle freely.
  task automatic drive_random();
    rnd           = $urandom();
    mlu_carry_out = rnd[0];
    mlu_negative  = rnd[1];
    interrupt     = rnd[2];
  endtask

  // Sample the word mid-cycle, then drive the next inputs.
  task automatic next_word();
    @(negedge clk);
    w = control_word;
    drive_random();
  endtask

  task automatic add_row(input microcode_pkg::opcode_e op, input logic zero,
                         input logic [4:0] len, input logic [2:0] exp_sel,
                         input microcode_pkg::out_plane_e exp_out);
    row_t r;
    r.op      = op;
    r.zero    = zero;
    r.len     = len;
    r.exp_sel = exp_sel;
    r.exp_out = exp_out;
    rows.push_back(r);
  endtask

  // Program length from the opcode class and the compare result.
  function automatic int model_length(input microcode_pkg::opcode_e op, input logic zero);
    if (op == microcode_pkg::OP_BEQ) begin
      return zero ? BR_TAKEN_CYCLES : BR_SKIP_CYCLES;
    end else if (op == microcode_pkg::OP_BNE) begin
      return zero ? BR_SKIP_CYCLES : BR_TAKEN_CYCLES;
    end
    return ALU_CYCLES;
  endfunction

  task automatic check_go_fetch();
    check_value("control_word.ctrl_data", 32'(w.ctrl_data), 32'(microcode_pkg::OP_FETCH));
    check_value("control_word.out_plane", 32'(w.out_plane), 32'(microcode_pkg::OUT_CTRL_DATA));
    check_value("control_word.in_plane", 32'(w.in_plane), 32'(microcode_pkg::IN_OPCODE));
    check_value("control_word.misc_plane", 32'(w.misc_plane), 32'd1);
    check_value("control_word.opcode_sel", 32'(w.opcode_sel), 32'd1);
  endtask

  task automatic run_fetch(input microcode_pkg::opcode_e op, input logic zero);
    int cnt;
    cnt           = 0;
    opword_opcode = op;     // Picked up by the last fetch step.
    mlu_zero      = !zero;  // Stale flag that the compare must overwrite.
    do begin
      next_word();
      cnt++;
      if (cnt == 2) begin   // Memory read into the opword.
        check_value("control_word.out_plane", 32'(w.out_plane), 32'(microcode_pkg::OUT_MMU));
        check_value("control_word.in_plane", 32'(w.in_plane), 32'(microcode_pkg::IN_OPWORD));
      end
    end while (!w.misc_plane);
    check_value("fetch_cycles", cnt, FETCH_CYCLES);
    check_value("control_word.opcode_sel", 32'(w.opcode_sel), 32'd0);
  endtask

  task automatic run_program(input row_t r);
    int   cnt;
    int   exp_len;
    logic branch;
    cnt     = 0;
    branch  = (r.op == microcode_pkg::OP_BEQ) || (r.op == microcode_pkg::OP_BNE);
    exp_len = model_length(r.op, r.zero);
    mlu_zero = r.zero;
    do begin
      next_word();
      cnt++;
      if (cnt == 1) begin  // First word must belong to the new opcode.
        check_value("control_word.in_plane", 32'(w.in_plane), 32'(microcode_pkg::IN_TMP0));
        check_value("control_word.out_plane", 32'(w.out_plane), 32'(microcode_pkg::OUT_REG));
        check_value("control_word.reg_sel", 32'(w.reg_sel),
                    branch ? 32'(microcode_pkg::REG_SEL_OPWORD0)
                           : 32'(microcode_pkg::REG_SEL_OPWORD1));
      end
      if (!branch && cnt == 3) begin  // Result write.
        check_value("control_word.out_plane", 32'(w.out_plane), 32'(r.exp_out));
        check_value("control_word.reg_sel", 32'(w.reg_sel),
                    32'(microcode_pkg::REG_SEL_OPWORD0));
        check_value("control_word.in_plane", 32'(w.in_plane), 32'(microcode_pkg::IN_REG));
        if (r.exp_out == microcode_pkg::OUT_SHIFTER) begin
          check_value("control_word.shifter_plane", 32'(w.shifter_plane), 32'(r.exp_sel));
        end else begin
          check_value("control_word.mlu_op", 32'(w.mlu_op), 32'(r.exp_sel));
        end
      end
      if (branch && cnt == 8) begin  // PC update of a taken branch.
        check_value("control_word.out_plane", 32'(w.out_plane), 32'(r.exp_out));
        check_value("control_word.in_plane", 32'(w.in_plane), 32'(microcode_pkg::IN_REG));
        check_value("control_word.ctrl_data", 32'(w.ctrl_data), `MC_REG_PC);
        check_value("control_word.mlu_op", 32'(w.mlu_op), 32'(r.exp_sel));
      end
    end while (!w.misc_plane);
    check_value("exec_cycles", cnt, exp_len);
    check_go_fetch();
  endtask

  initial begin
    int total;
    rnd           = $urandom(32'hc9b34a8b);
    arst_n        = 1'b0;
    opword_opcode = '0;
    mlu_zero      = 1'b0;
    mlu_carry_out = 1'b0;
    mlu_negative  = 1'b0;
    interrupt     = 1'b0;

    add_row(microcode_pkg::OP_ADDU, 1'b0, 5'd4, 3'(microcode_pkg::MLU_ADD),
            microcode_pkg::OUT_MLU);
    add_row(microcode_pkg::OP_AND,  1'b1, 5'd4, 3'(microcode_pkg::MLU_AND),
            microcode_pkg::OUT_MLU);
    add_row(microcode_pkg::OP_SLL,  1'b0, 5'd4, 3'(microcode_pkg::SHIFTER_LEFT),
            microcode_pkg::OUT_SHIFTER);
    add_row(microcode_pkg::OP_SRL,  1'b1, 5'd4, 3'(microcode_pkg::SHIFTER_RIGHT),
            microcode_pkg::OUT_SHIFTER);
    add_row(microcode_pkg::OP_ADD3, 1'b1, 5'd4, 3'(microcode_pkg::MLU_ADD),
            microcode_pkg::OUT_MLU);
    add_row(microcode_pkg::OP_OR3,  1'b0, 5'd4, 3'(microcode_pkg::MLU_OR),
            microcode_pkg::OUT_MLU);
    add_row(microcode_pkg::OP_XOR3, 1'b1, 5'd4, 3'(microcode_pkg::MLU_XOR),
            microcode_pkg::OUT_MLU);
    add_row(microcode_pkg::OP_SLL3, 1'b0, 5'd4, 3'(microcode_pkg::SHIFTER_LEFT),
            microcode_pkg::OUT_SHIFTER);
    add_row(microcode_pkg::OP_BEQ,  1'b1, 5'd9, 3'(microcode_pkg::MLU_ADD),
            microcode_pkg::OUT_MLU);  // Taken.
    add_row(microcode_pkg::OP_BEQ,  1'b0, 5'd4, 3'(microcode_pkg::MLU_ADD),
            microcode_pkg::OUT_MLU);
    add_row(microcode_pkg::OP_BNE,  1'b0, 5'd9, 3'(microcode_pkg::MLU_ADD),
            microcode_pkg::OUT_MLU);  // Taken.
    add_row(microcode_pkg::OP_BNE,  1'b1, 5'd4, 3'(microcode_pkg::MLU_ADD),
            microcode_pkg::OUT_MLU);

    total = RESET_CYCLES + RESET_PROG_CYCLES + MARGIN;
    foreach (rows[i]) begin
      total += int'(rows[i].len) + FETCH_CYCLES;
    end
    cycle_limit = total;

    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
    w      = control_word;  // Clear-r31 step.
    check_value("control_word.reg_sel", 32'(w.reg_sel), 32'(microcode_pkg::REG_SEL_CONTROL));
    check_value("control_word.ctrl_data", 32'(w.ctrl_data), `MC_REG_PC);
    check_value("control_word.in_plane", 32'(w.in_plane), 32'(microcode_pkg::IN_REG));
    check_value("control_word.misc_plane", 32'(w.misc_plane), 32'd0);
    next_word();
    check_go_fetch();

    foreach (rows[i]) begin
      run_fetch(rows[i].op, rows[i].zero);
      run_program(rows[i]);
    end

    $display("=== PASS ===");
    $finish;
  end

endmodule
